//--- Bender.yml
package:
  name: rx_frontend

sources:
  - src/rx_pkg.sv
  - src/sample_fifo.sv
  - src/cfo_nco.sv
  - src/cfo_mixer.sv
  - src/credit_tx.sv
  - src/rx_frontend.sv
  - target: test
    files:
      - bench/tb_rx_frontend.sv

//--- bench/tb_rx_frontend.sv
`timescale 1ns/1ns

module tb_rx_frontend;

    // about four times the length of all tests together
    localparam int MAX_CYCLES = 3000;
    localparam logic signed [rx_pkg::PHASE_W-1:0] QUARTER_TURN = 262144;

    logic                              clk_i = 1'b0;
    logic                              reset_ni;
    rx_pkg::iq_in_t                    in_data_i;
    logic                              in_valid_i;
    logic signed [rx_pkg::PHASE_W-1:0] cfo_delta_i;
    logic                              cfo_valid_i;
    logic                              credit_i = 1'b0;
    rx_pkg::iq_out_t                   out_data_o;
    logic                              out_valid_o;
    logic                              overflow_o;

    rx_pkg::iq_out_t exp_q [$];
    string           name_q [$];
    string           test_name = "reset_state";

    logic        [rx_pkg::PHASE_W-1:0] model_phase = '0;
    logic signed [rx_pkg::PHASE_W-1:0] model_inc = '0;

    int  credits_left = 0;
    int  received = 0;
    int  returned = 0;
    bit  credit_enable = 1'b1;
    int  cycles = 0;
    int  value_errors = 0;
    int  protocol_errors = 0;

    rx_frontend i_rx_frontend (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .cfo_delta_i (cfo_delta_i),
        .cfo_valid_i (cfo_valid_i),
        .credit_i    (credit_i),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .overflow_o  (overflow_o)
    );

    always #50 clk_i = ~clk_i;

    // table entries at multiples of a quarter turn are exact,
    // so a quarter-turn phase is a plain swap and negate
    function automatic rx_pkg::iq_out_t rotate_quarters(
        input logic signed [rx_pkg::IQ_IN_W-1:0] re,
        input logic signed [rx_pkg::IQ_IN_W-1:0] im,
        input logic        [1:0]                 quarters
    );
        logic signed [rx_pkg::IQ_OUT_W-1:0] re_x;
        logic signed [rx_pkg::IQ_OUT_W-1:0] im_x;
        rx_pkg::iq_out_t                    r;
        re_x = re;
        im_x = im;
        case (quarters)
            2'd0: begin
                r.re = re_x;
                r.im = im_x;
            end
            2'd1: begin
                r.re = -im_x;
                r.im = re_x;
            end
            2'd2: begin
                r.re = -re_x;
                r.im = -im_x;
            end
            default: begin
                r.re = im_x;
                r.im = -re_x;
            end
        endcase
        return r;
    endfunction

    // ------------------------------
    // checks
    // ------------------------------
    assert property (@(posedge clk_i) !reset_ni |=> !out_valid_o && !overflow_o)
    else begin
        protocol_errors++;
        $display("out_valid_o or overflow_o high during or right after reset");
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni) out_valid_o |-> credits_left > 0)
    else begin
        protocol_errors++;
        $display("out_valid_o high with no credit left");
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni) overflow_o |=> overflow_o)
    else begin
        protocol_errors++;
        $display("overflow_o dropped before reset");
    end

    always @(posedge clk_i) begin : monitor
        rx_pkg::iq_out_t expected;
        string           name;
        if (!reset_ni) begin
            credits_left = rx_pkg::CREDIT_INIT;
        end else begin
            credits_left = credits_left + int'(credit_i) - int'(out_valid_o);
            if (out_valid_o) begin
                received++;
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("output %h arrived with no sample expected", out_data_o);
                end else begin
                    expected = exp_q.pop_front();
                    name = name_q.pop_front();
                    assert (out_data_o == expected)
                    else begin
                        value_errors++;
                        $display("CHECK FAILED %s: expected %h, actual %h",
                                 name, expected, out_data_o);
                    end
                end
            end
        end
    end

    // consumer hands back one credit per received sample
    always @(negedge clk_i) begin
        if (reset_ni && credit_enable && returned < received) begin
            credit_i = 1'b1;
            returned++;
        end else begin
            credit_i = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d samples never arrived",
                     cycles, exp_q.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic send_burst(input int count, input int kept);
        int                                r;
        logic signed [rx_pkg::IQ_IN_W-1:0] re;
        logic signed [rx_pkg::IQ_IN_W-1:0] im;
        for (int i = 0; i < count; i++) begin
            r = int'($urandom_range(3600)) - 1800;
            re = r[rx_pkg::IQ_IN_W-1:0];
            r = int'($urandom_range(3600)) - 1800;
            im = r[rx_pkg::IQ_IN_W-1:0];
            @(negedge clk_i);
            in_data_i.re = re;
            in_data_i.im = im;
            in_valid_i = 1'b1;
            // samples past the FIFO capacity are lost and never rotate
            if (i < kept) begin
                exp_q.push_back(rotate_quarters(re, im, model_phase[rx_pkg::PHASE_W-1 -: 2]));
                name_q.push_back(test_name);
                model_phase = model_phase + model_inc;
            end
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    task automatic apply_cfo(input logic signed [rx_pkg::PHASE_W-1:0] delta);
        @(negedge clk_i);
        cfo_delta_i = delta;
        cfo_valid_i = 1'b1;
        @(negedge clk_i);
        cfo_valid_i = 1'b0;
        cfo_delta_i = '0;
        model_inc = model_inc - delta;
    endtask

    task automatic set_credits(input bit on);
        @(posedge clk_i);
        credit_enable = on;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        while (returned != received) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
    endtask

    initial begin
        void'($urandom(93));
        reset_ni = 1'b0;
        in_data_i = '0;
        in_valid_i = 1'b0;
        cfo_delta_i = '0;
        cfo_valid_i = 1'b0;
        repeat (16) @(negedge clk_i);
        assert (!out_valid_o && !overflow_o)
        else begin
            protocol_errors++;
            $display("outputs not low while reset is held");
        end
        reset_ni = 1'b1;
        repeat (2) @(negedge clk_i);

        test_name = "passthrough";
        send_burst(20, 20);
        wait_drained();

        // one quarter turn per sample
        test_name = "cfo_rotation";
        apply_cfo(-QUARTER_TURN);
        send_burst(9, 9);
        wait_drained();

        test_name = "cfo_relative";
        apply_cfo(QUARTER_TURN);
        send_burst(8, 8);
        wait_drained();

        test_name = "credit_limit";
        set_credits(1'b0);
        send_burst(6, 6);
        while (exp_q.size() > 2) begin
            @(posedge clk_i);
        end
        repeat (20) @(negedge clk_i);
        assert (exp_q.size() == 2)
        else begin
            protocol_errors++;
            $display("outputs went on without credits, %0d left", exp_q.size());
        end
        set_credits(1'b1);
        wait_drained();

        // credits, output FIFO and input FIFO absorb 4 + 8 + 16
        test_name = "overflow_flag";
        assert (!overflow_o)
        else begin
            protocol_errors++;
            $display("overflow_o high before the FIFOs filled");
        end
        set_credits(1'b0);
        send_burst(32, rx_pkg::CREDIT_INIT + rx_pkg::OUT_FIFO_DEPTH + rx_pkg::IN_FIFO_DEPTH);
        assert (overflow_o)
        else begin
            protocol_errors++;
            $display("overflow_o stayed low after the FIFOs filled");
        end
        set_credits(1'b1);
        wait_drained();
        assert (overflow_o)
        else begin
            protocol_errors++;
            $display("overflow_o cleared while draining");
        end

        repeat (4) @(negedge clk_i);
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
src/rx_pkg.sv
src/sample_fifo.sv
src/cfo_nco.sv
src/cfo_mixer.sv
src/credit_tx.sv
src/rx_frontend.sv
bench/tb_rx_frontend.sv

//--- src/cfo_mixer.sv
`timescale 1ns/1ns

module cfo_mixer (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  rx_pkg::iq_in_t                    in_data_i,
    input  logic                              in_empty_i,
    input  logic                              out_almost_full_i,
    input  logic signed [rx_pkg::PHASE_W-1:0] cfo_delta_i,
    input  logic                              cfo_valid_i,
    output logic                              pop_o,
    output rx_pkg::iq_out_t                   out_data_o,
    output logic                              out_valid_o
);

    logic signed [rx_pkg::TRIG_W-1:0] nco_cos;
    logic signed [rx_pkg::TRIG_W-1:0] nco_sin;

    logic                               s1_valid_q;
    logic signed [rx_pkg::IQ_OUT_W-1:0] s1_re_q;
    logic signed [rx_pkg::IQ_OUT_W-1:0] s1_im_q;
    logic signed [rx_pkg::TRIG_W-1:0]   s1_cos_q;
    logic signed [rx_pkg::TRIG_W-1:0]   s1_sin_q;

    logic signed [rx_pkg::IQ_OUT_W+rx_pkg::TRIG_W:0] rot_re;
    logic signed [rx_pkg::IQ_OUT_W+rx_pkg::TRIG_W:0] rot_im;

    // output FIFO keeps room for whatever is in flight
    assign pop_o = !in_empty_i && !out_almost_full_i;

    cfo_nco i_cfo_nco (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .cfo_delta_i (cfo_delta_i),
        .cfo_valid_i (cfo_valid_i),
        .step_i      (pop_o),
        .cos_o       (nco_cos),
        .sin_o       (nco_sin)
    );

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s1_valid_q  <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= pop_o;
            out_valid_o <= s1_valid_q;
        end
    end

    // ------------------------------
    // stage one, sample and phasor
    // ------------------------------
    always_ff @(posedge clk_i) begin
        s1_re_q  <= in_data_i.re;
        s1_im_q  <= in_data_i.im;
        s1_cos_q <= nco_cos;
        s1_sin_q <= nco_sin;
    end

    // ------------------------------
    // stage two, derotation
    // ------------------------------
    assign rot_re = s1_re_q * s1_cos_q - s1_im_q * s1_sin_q;
    assign rot_im = s1_re_q * s1_sin_q + s1_im_q * s1_cos_q;

    // arithmetic shift by TRIG_FRAC, truncated
    always_ff @(posedge clk_i) begin
        out_data_o.re <= rot_re[rx_pkg::TRIG_FRAC +: rx_pkg::IQ_OUT_W];
        out_data_o.im <= rot_im[rx_pkg::TRIG_FRAC +: rx_pkg::IQ_OUT_W];
    end

endmodule

//--- src/cfo_nco.sv
`timescale 1ns/1ns

module cfo_nco (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic signed [rx_pkg::PHASE_W-1:0] cfo_delta_i,
    input  logic                              cfo_valid_i,
    input  logic                              step_i,
    output logic signed [rx_pkg::TRIG_W-1:0]  cos_o,
    output logic signed [rx_pkg::TRIG_W-1:0]  sin_o
);

    logic signed [rx_pkg::PHASE_W-1:0] inc_q;
    logic        [rx_pkg::PHASE_W-1:0] phase_q;

    logic [rx_pkg::LUT_IDX_W-1:0] cos_idx;
    logic [rx_pkg::LUT_IDX_W-1:0] sin_idx;

    // ------------------------------
    // increment and phase
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            inc_q   <= '0;
            phase_q <= '0;
        end else begin
            // new estimates are relative to the running one
            if (cfo_valid_i) begin
                inc_q <= inc_q - cfo_delta_i;
            end
            // phase wraps modulo one turn
            if (step_i) begin
                phase_q <= phase_q + $unsigned(inc_q);
            end
        end
    end

    // ------------------------------
    // table lookup
    // ------------------------------
    assign cos_idx = phase_q[rx_pkg::PHASE_W-1 -: rx_pkg::LUT_IDX_W];
    assign sin_idx = cos_idx - rx_pkg::SIN_OFFSET;

    assign cos_o = rx_pkg::COS_LUT[cos_idx];
    assign sin_o = rx_pkg::COS_LUT[sin_idx];

endmodule

//--- src/credit_tx.sv
`timescale 1ns/1ns

module credit_tx (
    input  logic            clk_i,
    input  logic            reset_ni,
    input  logic            credit_i,
    input  rx_pkg::iq_out_t fifo_data_i,
    input  logic            fifo_empty_i,
    output logic            fifo_pop_o,
    output rx_pkg::iq_out_t out_data_o,
    output logic            out_valid_o
);

    logic [rx_pkg::CREDIT_W-1:0] credits_q;
    logic                        can_send;

    // a credit arriving now is usable right away
    assign can_send   = (credits_q != '0) || credit_i;
    assign fifo_pop_o = can_send && !fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            credits_q   <= rx_pkg::CREDIT_INIT;
            out_valid_o <= 1'b0;
        end else begin
            // returned and spent credits in one step
            credits_q   <= credits_q + credit_i - fifo_pop_o;
            out_valid_o <= fifo_pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            out_data_o <= fifo_data_i;
        end
    end

endmodule

//--- src/rx_frontend.sv
`timescale 1ns/1ns

module rx_frontend (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  rx_pkg::iq_in_t                    in_data_i,
    input  logic                              in_valid_i,
    input  logic signed [rx_pkg::PHASE_W-1:0] cfo_delta_i,
    input  logic                              cfo_valid_i,
    input  logic                              credit_i,
    output rx_pkg::iq_out_t                   out_data_o,
    output logic                              out_valid_o,
    output logic                              overflow_o
);

    rx_pkg::iq_in_t  in_fifo_data;
    logic            in_fifo_empty;
    logic            in_fifo_pop;

    rx_pkg::iq_out_t mix_data;
    logic            mix_valid;

    rx_pkg::iq_out_t out_fifo_data;
    logic            out_fifo_empty;
    logic            out_fifo_af;
    logic            out_fifo_pop;

    // ------------------------------
    // input side
    // ------------------------------
    sample_fifo #(
        .payload_t (rx_pkg::iq_in_t),
        .DEPTH     (rx_pkg::IN_FIFO_DEPTH)
    ) i_in_fifo (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .wr_data_i     (in_data_i),
        .wr_valid_i    (in_valid_i),
        .pop_i         (in_fifo_pop),
        .rd_data_o     (in_fifo_data),
        .empty_o       (in_fifo_empty),
        .almost_full_o (),
        .overflow_o    (overflow_o)
    );

    cfo_mixer i_cfo_mixer (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .in_data_i         (in_fifo_data),
        .in_empty_i        (in_fifo_empty),
        .out_almost_full_i (out_fifo_af),
        .cfo_delta_i       (cfo_delta_i),
        .cfo_valid_i       (cfo_valid_i),
        .pop_o             (in_fifo_pop),
        .out_data_o        (mix_data),
        .out_valid_o       (mix_valid)
    );

    // ------------------------------
    // output side
    // ------------------------------
    // slack covers the mixer pipeline
    sample_fifo #(
        .payload_t (rx_pkg::iq_out_t),
        .DEPTH     (rx_pkg::OUT_FIFO_DEPTH),
        .AF_SLACK  (rx_pkg::MIX_LATENCY)
    ) i_out_fifo (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .wr_data_i     (mix_data),
        .wr_valid_i    (mix_valid),
        .pop_i         (out_fifo_pop),
        .rd_data_o     (out_fifo_data),
        .empty_o       (out_fifo_empty),
        .almost_full_o (out_fifo_af),
        .overflow_o    ()
    );

    credit_tx i_credit_tx (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .credit_i     (credit_i),
        .fifo_data_i  (out_fifo_data),
        .fifo_empty_i (out_fifo_empty),
        .fifo_pop_o   (out_fifo_pop),
        .out_data_o   (out_data_o),
        .out_valid_o  (out_valid_o)
    );

endmodule

//--- src/rx_pkg.sv
package rx_pkg;

    // ------------------------------
    // sample formats
    // ------------------------------
    localparam int IQ_IN_W  = 12;
    localparam int IQ_OUT_W = 16;

    // re in the low half, im in the high half
    typedef struct packed {
        logic signed [IQ_IN_W-1:0] im;
        logic signed [IQ_IN_W-1:0] re;
    } iq_in_t;

    typedef struct packed {
        logic signed [IQ_OUT_W-1:0] im;
        logic signed [IQ_OUT_W-1:0] re;
    } iq_out_t;

    // ------------------------------
    // oscillator
    // ------------------------------
    localparam int PHASE_W   = 20;
    localparam int LUT_IDX_W = 4;
    localparam int LUT_SIZE  = 2 ** LUT_IDX_W;
    localparam int TRIG_W    = 16;
    localparam int TRIG_FRAC = 14;

    // sine is cosine a quarter turn back
    localparam logic [LUT_IDX_W-1:0] SIN_OFFSET = LUT_IDX_W'(LUT_SIZE / 4);

    // cos(k * 22.5 deg) in Q2.14
    localparam logic signed [TRIG_W-1:0] COS_LUT [LUT_SIZE] = '{
        16384,  15137,  11585,   6270,
            0,  -6270, -11585, -15137,
       -16384, -15137, -11585,  -6270,
            0,   6270,  11585,  15137
    };

    // ------------------------------
    // flow control
    // ------------------------------
    localparam int IN_FIFO_DEPTH  = 16;
    localparam int OUT_FIFO_DEPTH = 8;
    localparam int MIX_LATENCY    = 2;

    localparam int CREDIT_W = 3;
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(4);

endpackage

//--- src/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16,
    parameter int  AF_SLACK  = 1
) (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  payload_t wr_data_i,
    input  logic     wr_valid_i,
    input  logic     pop_i,
    output payload_t rd_data_o,
    output logic     empty_o,
    output logic     almost_full_o,
    output logic     overflow_o
);

    payload_t mem_q [DEPTH];

    // DEPTH is a power of two, pointers wrap on their own
    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;

    logic full;
    logic do_write;
    logic do_pop;

    assign full          = (count_q == DEPTH);
    assign empty_o       = (count_q == '0);
    assign almost_full_o = (count_q >= DEPTH - AF_SLACK);
    assign do_write      = wr_valid_i && !full;
    assign do_pop        = pop_i && !empty_o;
    assign rd_data_o     = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // sticky until reset
            if (wr_valid_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule
